//--- icache.f
+incdir+common
common/icache_pkg.sv
common/way_if.sv
design/sync_ram.sv
icache/icache_way.sv
icache/icache_ctrl.sv
design/icache_top.sv
test/tb_icache_top.sv

//--- run_sim.sh
#!/bin/sh
# build the icache testbench with Verilator, run it and judge the log
verilator --binary --timing -f icache.f --top-module tb_icache_top \
        -Mdir obj_dir -o tb_icache_top \
    && ./obj_dir/tb_icache_top | tee sim.log \
    && grep -q "ALL CHECKS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- test/tb_icache_top.sv
// ---------------------------------------------------------------------------
// icache testbench
// random fetches checked against a reference cache model, with a memory
// responder that answers refills after random delays
// ---------------------------------------------------------------------------
`include "icache_config.svh"

module tb_icache_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT  = 200;
    localparam int MEM_IDLE = 0;
    localparam int MEM_RDY  = 1;
    localparam int MEM_RET  = 2;

    // accepted fetch still waiting for data_ok
    typedef struct packed {
        logic [31:0] addr;
        logic        hit;
        logic [31:0] cycle;
    } pending_t;

    logic                      clk;
    logic                      reset;
    logic                      valid;
    logic [`ICACHE_ADDR_W-1:0] addr;
    logic                      addr_ok;
    logic                      data_ok;
    logic [`ICACHE_WORD_W-1:0] rdata;
    logic                      rd_req;
    logic [`ICACHE_ADDR_W-1:0] rd_addr;
    logic                      rd_rdy;
    logic                      ret_valid;
    logic [`ICACHE_LINE_W-1:0] ret_data;

    // model state: tag and valid per set and way, victim way per set
    logic [19:0] m_tag [256][2];
    logic        m_valid [256][2];
    logic        m_lru [256];

    pending_t    pending [$];
    logic [31:0] lfsr;
    logic [31:0] held_addr;
    logic        hung;
    string       test_name;
    int          cycle;
    int          mem_phase;
    int          wait_cnt;
    int          last_ret_cycle;
    int          last_accept;
    int          refills;
    int          model_misses;
    int          refills0;
    int          misses0;
    int          errors;
    int          test_errors;
    int          checks;
    int          tests_run;

    icache_top i_icache_top (.*);

    always #20 clk = ~clk;

    // galois LFSR, one bit per step
    function automatic logic lfsr_step();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_addr(input logic [19:0] tag, input logic [7:0] set,
                                              input logic [1:0] word);
        return {tag, set, word, 2'b00};
    endfunction

    // memory contents, a fixed mix of the whole word address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] w;
        w = {a[31:2], 2'b00};
        return (w * 32'h9e37_79b1) ^ {w[7:0], w[31:8]};
    endfunction

    function automatic logic [127:0] mem_line(input logic [31:0] a);
        logic [127:0] l;
        l = '0;
        for (int i = 0; i < 4; i++) begin
            l[i*32 +: 32] = mem_word({a[31:4], 4'h0} + 32'(i * 4));
        end
        return l;
    endfunction

    // hit predict, first free way else LRU way on a miss
    function automatic logic model_access(input logic [31:0] a);
        logic [19:0] t;
        logic [7:0]  s;
        logic        w;
        logic        hit;
        t   = a[31:12];
        s   = a[11:4];
        hit = 1'b1;
        if (m_valid[s][0] && m_tag[s][0] == t) begin
            w = 1'b0;
        end else if (m_valid[s][1] && m_tag[s][1] == t) begin
            w = 1'b1;
        end else begin
            hit = 1'b0;
            w   = !m_valid[s][0] ? 1'b0 : !m_valid[s][1] ? 1'b1 : m_lru[s];
            m_valid[s][w] = 1'b1;
            m_tag[s][w]   = t;
            model_misses++;
        end
        m_lru[s] = ~w;
        return hit;
    endfunction

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("CHECK FAILED %s %s expected %0h actual %0h", test_name, what,
                     expected, actual);
            count_error();
        end
    endtask

    // memory side, one call per falling edge
    task automatic memory_step();
        pending_t p;
        ret_valid = 1'b0;
        case (mem_phase)
            MEM_IDLE: begin
                if (rd_req) begin
                    refills++;
                    held_addr = rd_addr;
                    wait_cnt  = rand_bits(3);
                    mem_phase = MEM_RDY;
                    if (pending.size() == 0) begin
                        $display("%s: rd_req raised with no fetch outstanding", test_name);
                        count_error();
                    end else begin
                        p = pending[$];
                        check_value("miss predicted", 0, {31'b0, p.hit});
                        check_value("rd_addr", {p.addr[31:4], 4'h0}, rd_addr);
                        check_value("rd_req delay", p.cycle + 1, cycle);
                    end
                end
            end
            MEM_RDY: begin
                if (rd_rdy) begin
                    // accepted at the last rising edge
                    rd_rdy    = 1'b0;
                    wait_cnt  = rand_bits(3) % 7;
                    mem_phase = MEM_RET;
                end else begin
                    check_value("rd_req held", 1, {31'b0, rd_req});
                    check_value("rd_addr held", held_addr, rd_addr);
                end
            end
            default: begin
                check_value("rd_req during refill", 0, {31'b0, rd_req});
            end
        endcase
        if (mem_phase == MEM_RDY) begin
            if (wait_cnt == 0) begin
                rd_rdy = 1'b1;
            end else begin
                wait_cnt--;
            end
        end else if (mem_phase == MEM_RET) begin
            if (wait_cnt == 0) begin
                ret_valid      = 1'b1;
                ret_data       = mem_line(held_addr);
                last_ret_cycle = cycle;
                mem_phase      = MEM_IDLE;
            end else begin
                wait_cnt--;
            end
        end
    endtask

    // replies come back in order, hits one cycle after accept
    task automatic reply_step();
        pending_t p;
        if (data_ok) begin
            if (pending.size() == 0) begin
                $display("%s: data_ok pulsed with no fetch outstanding", test_name);
                count_error();
            end else begin
                p = pending.pop_front();
                check_value("rdata", mem_word(p.addr), rdata);
                if (p.hit) begin
                    check_value("hit latency", p.cycle + 1, cycle);
                end else begin
                    check_value("reply after ret_valid", last_ret_cycle + 1, cycle);
                end
            end
        end
    endtask

    task automatic tick();
        @(negedge clk);
        cycle++;
        memory_step();
        reply_step();
    endtask

    // hold valid until addr_ok, then log the fetch with its prediction
    task automatic issue(input logic [31:0] a);
        pending_t p;
        int       waited;
        waited = 0;
        valid  = 1'b1;
        addr   = a;
        while (!hung && !addr_ok) begin
            tick();
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout in %s waiting for addr_ok", test_name);
                count_error();
                hung = 1'b1;
            end
        end
        if (!hung) begin
            p.addr      = a;
            p.hit       = model_access(a);
            p.cycle     = cycle;
            last_accept = cycle;
            pending.push_back(p);
            tick();
        end
        valid = 1'b0;
    endtask

    task automatic wait_replies();
        int waited;
        waited = 0;
        while (!hung && (pending.size() != 0 || mem_phase != MEM_IDLE)) begin
            tick();
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout in %s with %0d replies missing", test_name, pending.size());
                count_error();
                hung = 1'b1;
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        refills0    = refills;
        misses0     = model_misses;
        tests_run++;
    endtask

    task automatic finish_test();
        check_value("refills against model", model_misses - misses0, refills - refills0);
        if (test_errors == 0) begin
            $display("test %s: pass", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] s;
        logic [19:0] pool_tag [3];
        logic [7:0]  pool_set [4];
        logic [19:0] seq_tag [6];
        int          prev;
        pool_tag  = '{20'h00123, 20'h0abcd, 20'h7f00e};
        pool_set  = '{8'h10, 8'h11, 8'h90, 8'hff};
        seq_tag   = '{20'h0aaaa, 20'h0bbbb, 20'h0cccc, 20'h0aaaa, 20'h0cccc, 20'h0bbbb};
        lfsr      = 32'd96;
        clk       = 1'b0;
        reset     = 1'b1;
        valid     = 1'b0;
        addr      = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        hung      = 1'b0;
        prev      = 0;
        mem_phase = MEM_IDLE;
        for (int i = 0; i < 256; i++) begin
            m_valid[i][0] = 1'b0;
            m_valid[i][1] = 1'b0;
            m_lru[i]      = 1'b0;
        end
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
        end
        reset = 1'b0;

        start_test("cold_miss");
        check_value("addr_ok after reset", 1, {31'b0, addr_ok});
        check_value("data_ok after reset", 0, {31'b0, data_ok});
        check_value("rd_req after reset", 0, {31'b0, rd_req});
        for (int i = 0; i < 8; i++) begin
            r = rand_bits(2);
            issue(make_addr(20'h01234, 8'h20 + 8'(i), r[1:0]));
            wait_replies();
        end
        check_value("cold refills", 8, refills - refills0);
        finish_test();

        // same lines again, other words
        start_test("hit_timing");
        for (int i = 0; i < 8; i++) begin
            r = rand_bits(2);
            issue(make_addr(20'h01234, 8'h20 + 8'(i), r[1:0]));
            wait_replies();
        end
        check_value("hit refills", 0, refills - refills0);
        finish_test();

        // each fetch enters in the cycle the one before it hits
        start_test("back_to_back");
        for (int i = 0; i < 8; i++) begin
            r = rand_bits(2);
            issue(make_addr(20'h01234, 8'h27 - 8'(i), r[1:0]));
            if (i > 0) begin
                check_value("accept gap", prev + 1, last_accept);
            end
            prev = last_accept;
        end
        wait_replies();
        finish_test();

        // three tags on one set, misses on A B C A and B
        start_test("replacement");
        for (int i = 0; i < 6; i++) begin
            issue(make_addr(seq_tag[i], 8'h40, 2'(i)));
            wait_replies();
        end
        check_value("replacement refills", 5, refills - refills0);
        finish_test();

        start_test("back_pressure");
        for (int i = 0; i < 6; i++) begin
            r = rand_bits(2);
            issue(make_addr(20'h05555, 8'h50 + 8'(i), r[1:0]));
            wait_replies();
        end
        check_value("back_pressure refills", 6, refills - refills0);
        finish_test();

        // small pool, three tags compete for each set
        start_test("random_mix");
        for (int i = 0; i < 300 && !hung; i++) begin
            r = rand_bits(2);
            s = rand_bits(2);
            issue(make_addr(pool_tag[r % 3], pool_set[s[1:0]], 2'(rand_bits(2))));
            if (rand_bits(1) != 0) begin
                tick();
            end
        end
        wait_replies();
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0 && !hung) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- design/icache_top.sv
// ---------------------------------------------------------------------------
// icache top level
// controller and two ways, fetch and memory ports as plain signals
// ---------------------------------------------------------------------------
`include "icache_config.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,

    // fetch unit
    input  logic                      valid,
    input  logic [`ICACHE_ADDR_W-1:0] addr,
    output logic                      addr_ok,
    output logic                      data_ok,
    output logic [`ICACHE_WORD_W-1:0] rdata,

    // memory bus
    output logic                      rd_req,
    output logic [`ICACHE_ADDR_W-1:0] rd_addr,
    input  logic                      rd_rdy,
    input  logic                      ret_valid,
    input  logic [`ICACHE_LINE_W-1:0] ret_data
);

    // address and line in their field views
    fetch_addr_t fetch_addr;
    line_t       ret_line;
    word_t       fetch_word;

    assign fetch_addr = addr;
    assign ret_line   = ret_data;
    assign rdata      = fetch_word;

    way_if way0_bus ();
    way_if way1_bus ();

    icache_ctrl i_icache_ctrl (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .addr      (fetch_addr),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (fetch_word),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_line),
        .way0      (way0_bus.ctrl),
        .way1      (way1_bus.ctrl)
    );

    icache_way i_icache_way0 (
        .clk   (clk),
        .reset (reset),
        .bus   (way0_bus.way)
    );

    icache_way i_icache_way1 (
        .clk   (clk),
        .reset (reset),
        .bus   (way1_bus.way)
    );

endmodule

//--- icache/icache_ctrl.sv
// ---------------------------------------------------------------------------
// icache controller
// lookup, miss and refill FSM with hit detect, LRU victim choice and
// word select toward the fetch unit
// ---------------------------------------------------------------------------
`include "icache_config.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,

    // fetch side
    input  logic                      valid,
    input  fetch_addr_t               addr,
    output logic                      addr_ok,
    output logic                      data_ok,
    output word_t                     rdata,

    // memory side
    output logic                      rd_req,
    output logic [`ICACHE_ADDR_W-1:0] rd_addr,
    input  logic                      rd_rdy,
    input  logic                      ret_valid,
    input  line_t                     ret_data,

    // the two ways
    way_if.ctrl                       way0,
    way_if.ctrl                       way1
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL
    } state_t;

    state_t state;
    state_t state_nxt;

    // accepted request, held through lookup and refill
    fetch_addr_t req_q;

    // per set, the way to evict next
    logic [SETS-1:0] lru_q;

    // way picked at the miss, written at refill
    logic victim_q;

    // refill word goes out one cycle after ret_valid
    logic  refill_done_q;
    word_t refill_word_q;

    logic                  hit0;
    logic                  hit1;
    logic                  hit;
    logic                  lookup_hit;
    logic                  lookup_miss;
    logic                  accept;
    logic                  ret_fire;
    logic                  victim;
    logic                  use_req_index;
    logic [WORD_SEL_W-1:0] word_sel;
    line_t                 hit_line;

    // tag compare against the lookup address
    assign hit0 = way0.rvalid && (way0.rtag == req_q.tag);
    assign hit1 = way1.rvalid && (way1.rtag == req_q.tag);
    assign hit  = hit0 || hit1;

    assign lookup_hit  = (state == LOOKUP) && hit;
    assign lookup_miss = (state == LOOKUP) && !hit;

    // next request may enter while a hit returns
    assign addr_ok = (state == IDLE) || lookup_hit;
    assign accept  = valid && addr_ok;

    assign ret_fire = (state == REFILL) && ret_valid;

    // first empty way, else the LRU one
    assign victim = !way0.rvalid ? 1'b0 :
                    !way1.rvalid ? 1'b1 :
                    lru_q[req_q.index];

    // word within the line, offset bits 3:2
    assign word_sel = req_q.offset[`ICACHE_OFFSET_W-1 -: WORD_SEL_W];
    assign hit_line = hit0 ? way0.rline : way1.rline;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (valid) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    // stay for a pipelined request
                    state_nxt = valid ? LOOKUP : IDLE;
                end else begin
                    // rd_req already up this cycle
                    state_nxt = rd_rdy ? REFILL : MISS;
                end
            end
            MISS: begin
                if (rd_rdy) begin
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // capture request on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= addr;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_miss) begin
            victim_q <= victim;
        end
    end

    // hit makes the other way LRU, refill makes the victim MRU
    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (lookup_hit) begin
            lru_q[req_q.index] <= hit0;
        end else if (ret_fire) begin
            lru_q[req_q.index] <= ~victim_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            refill_done_q <= 1'b0;
        end else begin
            refill_done_q <= ret_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (ret_fire) begin
            refill_word_q <= ret_data[word_sel];
        end
    end

    // reply to fetch
    assign data_ok = lookup_hit || refill_done_q;
    assign rdata   = (state == LOOKUP) ? hit_line[word_sel] : refill_word_q;

    // line read request, held until rd_rdy
    assign rd_req  = lookup_miss || (state == MISS);
    assign rd_addr = {req_q.tag, req_q.index, {`ICACHE_OFFSET_W{1'b0}}};

    // ways follow the incoming address, or the miss address during refill
    assign use_req_index = (state == MISS) || (state == REFILL);

    assign way0.index = use_req_index ? req_q.index : addr.index;
    assign way1.index = use_req_index ? req_q.index : addr.index;

    // refill goes into the victim only
    assign way0.we    = ret_fire && !victim_q;
    assign way1.we    = ret_fire && victim_q;
    assign way0.wtag  = req_q.tag;
    assign way1.wtag  = req_q.tag;
    assign way0.wline = ret_data;
    assign way1.wline = ret_data;

endmodule

//--- icache/icache_way.sv
// ---------------------------------------------------------------------------
// icache way
// tag RAM, line RAM and a valid bit per set, read one cycle after index
// ---------------------------------------------------------------------------
module icache_way
    import icache_pkg::*;
(
    input  logic clk,
    input  logic reset,
    way_if.way   bus
);

    // one valid bit per set, cleared on reset
    logic [SETS-1:0] valid_q;

    // tag store
    sync_ram #(
        .payload_t (tag_t),
        .DEPTH     (SETS)
    ) i_tag_ram (
        .clk   (clk),
        .we    (bus.we),
        .addr  (bus.index),
        .wdata (bus.wtag),
        .rdata (bus.rtag)
    );

    // line store
    sync_ram #(
        .payload_t (line_t),
        .DEPTH     (SETS)
    ) i_line_ram (
        .clk   (clk),
        .we    (bus.we),
        .addr  (bus.index),
        .wdata (bus.wline),
        .rdata (bus.rline)
    );

    // valid array, set on refill write
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (bus.we) begin
            valid_q[bus.index] <= 1'b1;
        end
    end

    // read valid lines up with the RAM outputs
    // old value on a same-cycle write, as the RAMs do
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.rvalid <= 1'b0;
        end else begin
            bus.rvalid <= valid_q[bus.index];
        end
    end

endmodule

//--- design/sync_ram.sv
// ---------------------------------------------------------------------------
// single-port synchronous RAM
// registered read, old data returned on a write to the same address
// ---------------------------------------------------------------------------
module sync_ram #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 256
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  payload_t                 wdata,
    output payload_t                 rdata
);

    // storage, contents undefined until written
    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        // read sees the value from before this edge
        rdata <= mem[addr];
        if (we) begin
            mem[addr] <= wdata;
        end
    end

endmodule

//--- common/way_if.sv
// ---------------------------------------------------------------------------
// controller to way link
// set index and refill write going out, tag, valid and line coming back
// ---------------------------------------------------------------------------
`include "icache_config.svh"

interface way_if
    import icache_pkg::*;
();

    // from the controller
    logic [`ICACHE_INDEX_W-1:0] index;
    logic                       we;
    tag_t                       wtag;
    line_t                      wline;

    // from the way, one cycle after index
    tag_t                       rtag;
    logic                       rvalid;
    line_t                      rline;

    modport ctrl (
        output index,
        output we,
        output wtag,
        output wline,
        input  rtag,
        input  rvalid,
        input  rline
    );

    modport way (
        input  index,
        input  we,
        input  wtag,
        input  wline,
        output rtag,
        output rvalid,
        output rline
    );

endinterface

//--- common/icache_pkg.sv
// ---------------------------------------------------------------------------
// icache types
// address fields, tag entries, words and cache lines
// ---------------------------------------------------------------------------
`include "icache_config.svh"

package icache_pkg;

    // number of sets held by each way
    localparam int SETS = 1 << `ICACHE_INDEX_W;

    // words in one line and the offset bits that pick one
    localparam int WORDS_PER_LINE = `ICACHE_LINE_W / `ICACHE_WORD_W;
    localparam int WORD_SEL_W     = $clog2(WORDS_PER_LINE);

    // tag entry as kept in the tag RAM
    typedef logic [`ICACHE_TAG_W-1:0] tag_t;

    // one instruction word
    typedef logic [`ICACHE_WORD_W-1:0] word_t;

    // line as packed words, word 0 in the low bits
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    // fetch address split into its fields
    typedef struct packed {
        tag_t                        tag;
        logic [`ICACHE_INDEX_W-1:0]  index;
        logic [`ICACHE_OFFSET_W-1:0] offset;
    } fetch_addr_t;

endpackage

//--- common/icache_config.svh
// ---------------------------------------------------------------------------
// icache geometry
// two-way, 256 sets of 16-byte lines, 32-bit fetch addresses
// ---------------------------------------------------------------------------
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// full fetch address
`define ICACHE_ADDR_W   32
// set select, 256 sets
`define ICACHE_INDEX_W  8
// byte offset inside a line
`define ICACHE_OFFSET_W 4
// remaining upper address bits
`define ICACHE_TAG_W    20
// one refill beat is a whole line
`define ICACHE_LINE_W   128
// instruction word returned to fetch
`define ICACHE_WORD_W   32

`endif
